// File: hw/ipv4_pkg.sv
/* IPv4 header field types, fixed version and IHL values,
   TTL forwarding limit and the statistics register map */
package ipv4_pkg;

    ////////////////////////////////////////////////////////////
    // Header field widths

    // One header word, a checksum or a folded partial sum
    typedef logic [15:0] word_t;

    typedef logic [31:0] addr_t;
    typedef logic [7:0]  ttl_t;
    typedef logic [7:0]  proto_t;
    typedef logic [5:0]  dscp_t;
    typedef logic [1:0]  ecn_t;
    typedef logic [2:0]  flags_t;
    typedef logic [12:0] frag_off_t;

    // Unfolded sum, wide enough for ten words without loss
    typedef logic [19:0] sum_t;

    ////////////////////////////////////////////////////////////
    // Fixed header values

    localparam logic [3:0] IP_VERSION = 4'd4;

    // No options, header is always five 32-bit words
    localparam logic [3:0] IP_IHL = 4'd5;

    // Below this the packet would leave with a TTL of zero
    localparam ttl_t TTL_MIN_FWD = 8'd2;

    ////////////////////////////////////////////////////////////
    // Statistics registers

    typedef logic [31:0] count_t;
    typedef logic [1:0]  wb_adr_t;

    localparam wb_adr_t REG_GOOD    = 2'd0;
    localparam wb_adr_t REG_BAD     = 2'd1;
    localparam wb_adr_t REG_EXPIRED = 2'd2;

endpackage

// File: hw/ipv4_hdr_if.sv
/* Parsed IPv4 header bus, one header per req pulse */
`timescale 1ns/1ns

interface ipv4_hdr_if;

    logic                   req;
    ipv4_pkg::dscp_t        dscp;
    ipv4_pkg::ecn_t         ecn;
    ipv4_pkg::word_t        length;
    ipv4_pkg::word_t        identification;
    ipv4_pkg::flags_t       flags;
    ipv4_pkg::frag_off_t    fragment_offset;
    ipv4_pkg::ttl_t         ttl;
    ipv4_pkg::word_t        hdr_chksum;
    ipv4_pkg::proto_t       protocol;
    ipv4_pkg::addr_t        source_ip;
    ipv4_pkg::addr_t        dest_ip;

    // Fields are only meaningful in the cycle req is high
    modport src (
        output req, dscp, ecn, length, identification, flags,
        output fragment_offset, ttl, hdr_chksum, protocol, source_ip, dest_ip
    );

    modport sink (
        input req, dscp, ecn, length, identification, flags,
        input fragment_offset, ttl, hdr_chksum, protocol, source_ip, dest_ip
    );

endinterface

// File: hw/ipv4_checksum_verify.sv
/* Two-stage IPv4 header checksum check, result two cycles after req */
`timescale 1ns/1ns

module ipv4_checksum_verify (
    input  logic            clk,
    input  logic            rst,
    ipv4_hdr_if.sink        hdr,
    output logic            chk_valid,
    output logic            chk_ok
);

    ipv4_pkg::word_t    first_word;
    ipv4_pkg::sum_t     sum_d;
    ipv4_pkg::sum_t     sum_q;
    logic               sum_valid_q;
    logic [16:0]        fold_1;
    ipv4_pkg::word_t    fold_2;

    ////////////////////////////////////////////////////////////
    // Stage one, raw sum of the ten header words

    assign first_word = {ipv4_pkg::IP_VERSION, ipv4_pkg::IP_IHL, hdr.dscp, hdr.ecn};

    // Checksum field is included, a good header sums to all ones
    always_comb begin
        sum_d = ipv4_pkg::sum_t'(first_word)
              + ipv4_pkg::sum_t'(hdr.length)
              + ipv4_pkg::sum_t'(hdr.identification)
              + ipv4_pkg::sum_t'({hdr.flags, hdr.fragment_offset})
              + ipv4_pkg::sum_t'({hdr.ttl, hdr.protocol})
              + ipv4_pkg::sum_t'(hdr.hdr_chksum)
              + ipv4_pkg::sum_t'(hdr.source_ip[31:16])
              + ipv4_pkg::sum_t'(hdr.source_ip[15:0])
              + ipv4_pkg::sum_t'(hdr.dest_ip[31:16])
              + ipv4_pkg::sum_t'(hdr.dest_ip[15:0]);
    end

    always_ff @(posedge clk) begin
        sum_q <= sum_d;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid_q <= 1'b0;
        end else begin
            sum_valid_q <= hdr.req;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two, end-around carry and compare

    // Second fold catches the carry out of the first
    assign fold_1 = {1'b0, sum_q[15:0]} + {13'd0, sum_q[19:16]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    always_ff @(posedge clk) begin
        chk_ok <= (fold_2 == '1);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            chk_valid <= 1'b0;
        end else begin
            chk_valid <= sum_valid_q;
        end
    end

endmodule

// File: hw/ipv4_ttl_update.sv
/* Two-stage TTL decrement with incremental checksum update (RFC 1624) */
`timescale 1ns/1ns

module ipv4_ttl_update (
    input  logic                clk,
    input  logic                rst,
    ipv4_hdr_if.sink            hdr,
    output ipv4_pkg::ttl_t      upd_ttl,
    output ipv4_pkg::word_t     upd_chksum,
    output logic                upd_expired
);

    logic               expired_d;
    ipv4_pkg::ttl_t     ttl_dec;
    logic               valid_q;
    logic               expired_q;
    ipv4_pkg::ttl_t     ttl_q;
    ipv4_pkg::word_t    chk_inv_q;
    ipv4_pkg::word_t    old_inv_q;
    ipv4_pkg::word_t    new_word_q;
    ipv4_pkg::sum_t     sum;
    logic [16:0]        fold_1;
    ipv4_pkg::word_t    fold_2;

    ////////////////////////////////////////////////////////////
    // Stage one, expiry decision and the three terms

    assign expired_d = (hdr.ttl < ipv4_pkg::TTL_MIN_FWD);
    assign ttl_dec   = hdr.ttl - 8'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= hdr.req;
        end
    end

    // HC' = ~(~HC + ~m + m'), m is the TTL and protocol word
    always_ff @(posedge clk) begin
        if (hdr.req) begin
            expired_q  <= expired_d;
            ttl_q      <= expired_d ? hdr.ttl : ttl_dec;
            chk_inv_q  <= ~hdr.hdr_chksum;
            old_inv_q  <= ~{hdr.ttl, hdr.protocol};
            new_word_q <= {ttl_dec, hdr.protocol};
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage two, fold and complement

    assign sum    = ipv4_pkg::sum_t'(chk_inv_q) + ipv4_pkg::sum_t'(old_inv_q)
                  + ipv4_pkg::sum_t'(new_word_q);
    assign fold_1 = {1'b0, sum[15:0]} + {13'd0, sum[19:16]};
    assign fold_2 = fold_1[15:0] + {15'd0, fold_1[16]};

    // Outputs hold the last result between headers
    always_ff @(posedge clk) begin
        if (valid_q) begin
            upd_ttl     <= ttl_q;
            upd_expired <= expired_q;
            upd_chksum  <= expired_q ? ~chk_inv_q : ~fold_2;
        end
    end

endmodule

// File: hw/ipv4_hdr_stats.sv
/* Good, bad and expired header counters
   behind a Wishbone classic slave, any write clears */
`timescale 1ns/1ns

module ipv4_hdr_stats (
    input  logic                clk,
    input  logic                rst,
    input  logic                res_valid,
    input  logic                res_ok,
    input  logic                res_expired,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  ipv4_pkg::wb_adr_t   wb_adr,
    input  ipv4_pkg::count_t    wb_dat_w,
    output ipv4_pkg::count_t    wb_dat_r,
    output logic                wb_ack
);

    ipv4_pkg::count_t   good_cnt;
    ipv4_pkg::count_t   bad_cnt;
    ipv4_pkg::count_t   expired_cnt;
    logic               wb_req;
    logic               clear;

    ////////////////////////////////////////////////////////////
    // Bus decode

    // Ack is low for a cycle after each access
    assign wb_req = wb_cyc & wb_stb & ~wb_ack;

    // Write data carries no value, the write itself is the command
    assign clear = wb_req & wb_we;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_req && !wb_we) begin
            case (wb_adr)
                ipv4_pkg::REG_GOOD:    wb_dat_r <= good_cnt;
                ipv4_pkg::REG_BAD:     wb_dat_r <= bad_cnt;
                ipv4_pkg::REG_EXPIRED: wb_dat_r <= expired_cnt;
                default:               wb_dat_r <= '0;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // Counters

    // Bad checksum wins over expiry, a clear wins over everything
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            good_cnt    <= '0;
            bad_cnt     <= '0;
            expired_cnt <= '0;
        end else if (res_valid) begin
            if (!res_ok) begin
                bad_cnt <= bad_cnt + 32'd1;
            end else if (res_expired) begin
                expired_cnt <= expired_cnt + 32'd1;
            end else begin
                good_cnt <= good_cnt + 32'd1;
            end
        end
    end

endmodule

// File: hw/ipv4_forward_top.sv
/* IPv4 header check stage, checksum verify, TTL update and statistics */
`timescale 1ns/1ns

module ipv4_forward_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  ipv4_pkg::dscp_t         ip_dscp,
    input  ipv4_pkg::ecn_t          ip_ecn,
    input  ipv4_pkg::word_t         ip_length,
    input  ipv4_pkg::word_t         ip_identification,
    input  ipv4_pkg::flags_t        ip_flags,
    input  ipv4_pkg::frag_off_t     ip_fragment_offset,
    input  ipv4_pkg::ttl_t          ip_ttl,
    input  ipv4_pkg::word_t         ip_hdr_chksum,
    input  ipv4_pkg::proto_t        ip_protocol,
    input  ipv4_pkg::addr_t         ip_source_ip,
    input  ipv4_pkg::addr_t         ip_dest_ip,
    output logic                    out_valid,
    output logic                    out_chksum_ok,
    output logic                    out_drop,
    output ipv4_pkg::ttl_t          out_ttl,
    output ipv4_pkg::word_t         out_hdr_chksum,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  ipv4_pkg::wb_adr_t       wb_adr,
    input  ipv4_pkg::count_t        wb_dat_w,
    output ipv4_pkg::count_t        wb_dat_r,
    output logic                    wb_ack
);

    logic upd_expired;

    ipv4_hdr_if hdr ();

    assign hdr.req             = req;
    assign hdr.dscp            = ip_dscp;
    assign hdr.ecn             = ip_ecn;
    assign hdr.length          = ip_length;
    assign hdr.identification  = ip_identification;
    assign hdr.flags           = ip_flags;
    assign hdr.fragment_offset = ip_fragment_offset;
    assign hdr.ttl             = ip_ttl;
    assign hdr.hdr_chksum      = ip_hdr_chksum;
    assign hdr.protocol        = ip_protocol;
    assign hdr.source_ip       = ip_source_ip;
    assign hdr.dest_ip         = ip_dest_ip;

    ////////////////////////////////////////////////////////////
    // Both pipelines are two cycles, results line up

    ipv4_checksum_verify u_verify (
        .clk        (clk),
        .rst        (rst),
        .hdr        (hdr.sink),
        .chk_valid  (out_valid),
        .chk_ok     (out_chksum_ok)
    );

    ipv4_ttl_update u_ttl (
        .clk         (clk),
        .rst         (rst),
        .hdr         (hdr.sink),
        .upd_ttl     (out_ttl),
        .upd_chksum  (out_hdr_chksum),
        .upd_expired (upd_expired)
    );

    assign out_drop = ~out_chksum_ok | upd_expired;

    ipv4_hdr_stats u_stats (
        .clk         (clk),
        .rst         (rst),
        .res_valid   (out_valid),
        .res_ok      (out_chksum_ok),
        .res_expired (upd_expired),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

endmodule

// File: testbench/ipv4_ref.svh
/* Reference models for the IPv4 header checksum,
   the checksum check and the TTL update with a full checksum recomputation */
`ifndef IPV4_REF_SVH
`define IPV4_REF_SVH

// Ones' complement add with end-around carry
function automatic logic [15:0] ones_add(input logic [15:0] a, input logic [15:0] b);
    logic [16:0] s;
    s = {1'b0, a} + {1'b0, b};
    return s[15:0] + {15'd0, s[16]};
endfunction

function automatic logic [15:0] ones_sum(input logic [9:0][15:0] w);
    logic [15:0] acc;
    acc = 16'd0;
    for (int i = 0; i < 10; i++) begin
        acc = ones_add(acc, w[i]);
    end
    return acc;
endfunction

// Checksum over the header with its own field taken as zero
function automatic logic [15:0] gen_checksum(input logic [9:0][15:0] w);
    w[5] = 16'd0;
    return ~ones_sum(w);
endfunction

function automatic logic verify_checksum(input logic [9:0][15:0] w);
    return ones_sum(w) == 16'hffff;
endfunction

// New TTL in the upper byte, new checksum in the lower 16 bits
function automatic logic [23:0] ttl_update_ref(input logic [9:0][15:0] w);
    if (w[4][15:8] < ipv4_pkg::TTL_MIN_FWD) begin
        return {w[4][15:8], w[5]};
    end
    w[4][15:8] = w[4][15:8] - 8'd1;
    return {w[4][15:8], gen_checksum(w)};
endfunction

`endif

// File: testbench/ipv4_forward_tb.sv
/* Testbench for the IPv4 header check stage with random headers,
   an ordered compare process, Wishbone counter reads and a watchdog */
`timescale 1ns/1ns

module ipv4_forward_tb;

    localparam int CLK_PERIOD = 4;
    localparam int N_HDR      = 100;
    localparam int N_WB       = 7;
    localparam int TIMEOUT_NS = (N_HDR + N_WB) * 4 * CLK_PERIOD + 400;

    typedef struct packed {
        logic               ok;
        logic               drop;
        logic               check_chk;
        ipv4_pkg::ttl_t     ttl;
        ipv4_pkg::word_t    chksum;
    } exp_t;

    logic clk, rst, req;
    ipv4_pkg::dscp_t     ip_dscp;
    ipv4_pkg::ecn_t      ip_ecn;
    ipv4_pkg::word_t     ip_length, ip_identification, ip_hdr_chksum;
    ipv4_pkg::flags_t    ip_flags;
    ipv4_pkg::frag_off_t ip_fragment_offset;
    ipv4_pkg::ttl_t      ip_ttl, out_ttl;
    ipv4_pkg::proto_t    ip_protocol;
    ipv4_pkg::addr_t     ip_source_ip, ip_dest_ip;
    logic                out_valid, out_chksum_ok, out_drop;
    ipv4_pkg::word_t     out_hdr_chksum;
    logic                wb_cyc, wb_stb, wb_we, wb_ack;
    ipv4_pkg::wb_adr_t   wb_adr;
    ipv4_pkg::count_t    wb_dat_w, wb_dat_r;

    integer             seed;
    int                 error_count;
    exp_t               exp_q[$];
    exp_t               got_entry;
    ipv4_pkg::count_t   exp_good, exp_bad, exp_expired;

    `include "ipv4_ref.svh"

    ipv4_forward_top ipv4_forward_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic report_mismatch(input string field, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("mismatch at %0t ns: %s got %0h expected %0h", $time, field, got, expected);
        error_count++;
    endtask

    // Kind 0 good, 1 one checksum bit flipped, 2 good checksum with TTL 0 or 1
    task automatic make_header(input int kind, output logic [9:0][15:0] w);
        logic [31:0] r;
        ipv4_pkg::ttl_t ttl;
        r = $random(seed);
        w[0] = {ipv4_pkg::IP_VERSION, ipv4_pkg::IP_IHL, r[7:0]};
        w[1] = r[31:16];
        r = $random(seed);
        w[2] = r[15:0];
        w[3] = r[31:16];
        r = $random(seed);
        ttl = r[7:0];
        if (kind == 2) begin
            ttl = {7'd0, r[0]};
        end else if (kind == 0 && ttl < 8'd2) begin
            ttl = ttl + 8'd2;
        end
        w[4] = {ttl, r[15:8]};
        for (int i = 6; i < 10; i++) begin
            w[i] = r[31:16] ^ 16'(i * 16'h1357);
            r = $random(seed);
        end
        w[5] = gen_checksum(w);
        if (kind == 1) begin
            w[5][r[3:0]] = ~w[5][r[3:0]];
        end
    endtask

    task automatic drive_header(input logic [9:0][15:0] w);
        ip_dscp            = w[0][7:2];
        ip_ecn             = w[0][1:0];
        ip_length          = w[1];
        ip_identification  = w[2];
        ip_flags           = w[3][15:13];
        ip_fragment_offset = w[3][12:0];
        ip_ttl             = w[4][15:8];
        ip_protocol        = w[4][7:0];
        ip_hdr_chksum      = w[5];
        ip_source_ip       = {w[6], w[7]};
        ip_dest_ip         = {w[8], w[9]};
        req                = 1'b1;
    endtask

    // Expected result and counter sorting from the reference model
    task automatic push_expected(input logic [9:0][15:0] w);
        exp_t e;
        logic expired;
        expired     = w[4][15:8] < ipv4_pkg::TTL_MIN_FWD;
        e.ok        = verify_checksum(w);
        e.drop      = !e.ok || expired;
        e.check_chk = e.ok;
        {e.ttl, e.chksum} = ttl_update_ref(w);
        exp_q.push_back(e);
        if (!e.ok) begin
            exp_bad = exp_bad + 32'd1;
        end else if (expired) begin
            exp_expired = exp_expired + 32'd1;
        end else begin
            exp_good = exp_good + 32'd1;
        end
    endtask

    // Kind 3 picks one of the other kinds at random
    task automatic run_headers(input string name, input int num, input int kind,
                               input bit spaced);
        logic [9:0][15:0] w;
        logic [31:0] r;
        int start_err;
        int k;
        start_err = error_count;
        for (int i = 0; i < num; i++) begin
            r = $random(seed);
            k = (kind == 3) ? ((r[5:4] == 2'd3) ? 0 : int'(r[5:4])) : kind;
            if (spaced) begin
                repeat (int'(r[1:0])) begin
                    @(negedge clk);
                    req = 1'b0;
                end
            end
            make_header(k, w);
            @(negedge clk);
            drive_header(w);
            push_expected(w);
        end
        @(negedge clk);
        req = 1'b0;
        while (exp_q.size() != 0) @(negedge clk);
        $display("%s: %0d headers, %0d errors", name, num, error_count - start_err);
    endtask

    task automatic wb_access(input logic we, input ipv4_pkg::wb_adr_t adr,
                             output ipv4_pkg::count_t data);
        @(negedge clk);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = we;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        data   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_counter(input ipv4_pkg::wb_adr_t adr, input ipv4_pkg::count_t expected);
        ipv4_pkg::count_t data;
        wb_access(1'b0, adr, data);
        assert (data == expected) else report_mismatch("wb_dat_r", data, expected);
    endtask

    ////////////////////////////////////////////////////////////
    // Compare process, results in request order

    always @(negedge clk) begin
        if (!rst && out_valid) begin
            assert (exp_q.size() > 0) else begin
                $display("out_valid rose without a pending request at %0t ns", $time);
                error_count++;
            end
            if (exp_q.size() > 0) begin
                got_entry = exp_q.pop_front();
                assert (out_chksum_ok == got_entry.ok)
                    else report_mismatch("out_chksum_ok", 32'(out_chksum_ok), 32'(got_entry.ok));
                assert (out_drop == got_entry.drop)
                    else report_mismatch("out_drop", 32'(out_drop), 32'(got_entry.drop));
                assert (out_ttl == got_entry.ttl)
                    else report_mismatch("out_ttl", 32'(out_ttl), 32'(got_entry.ttl));
                if (got_entry.check_chk) begin
                    assert (out_hdr_chksum == got_entry.chksum)
                        else report_mismatch("out_hdr_chksum", 32'(out_hdr_chksum),
                                             32'(got_entry.chksum));
                end
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout, the run did not finish within %0d ns", TIMEOUT_NS);
        $display("test failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        ipv4_pkg::count_t dummy;
        int start_err;
        seed = 32'hff58;
        error_count = 0;
        exp_good = '0;
        exp_bad = '0;
        exp_expired = '0;
        rst = 1'b1;
        req = 1'b0;
        drive_header('0);
        req = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_headers("good headers back to back", 40, 0, 1'b0);
        run_headers("flipped checksum bit", 20, 1, 1'b0);
        run_headers("expired ttl", 10, 2, 1'b0);
        run_headers("spaced mixed headers", 30, 3, 1'b1);

        start_err = error_count;
        read_counter(ipv4_pkg::REG_GOOD, exp_good);
        read_counter(ipv4_pkg::REG_BAD, exp_bad);
        read_counter(ipv4_pkg::REG_EXPIRED, exp_expired);
        wb_dat_w = 32'hdead_beef;
        wb_access(1'b1, ipv4_pkg::REG_BAD, dummy);
        read_counter(ipv4_pkg::REG_GOOD, '0);
        read_counter(ipv4_pkg::REG_BAD, '0);
        read_counter(ipv4_pkg::REG_EXPIRED, '0);
        $display("wishbone counters: %0d accesses, %0d errors", N_WB, error_count - start_err);

        $display("Summary: good %0d, bad %0d, expired %0d, %0d errors",
                 exp_good, exp_bad, exp_expired, error_count);
        if (error_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+testbench
hw/ipv4_pkg.sv
hw/ipv4_hdr_if.sv
hw/ipv4_checksum_verify.sv
hw/ipv4_ttl_update.sv
hw/ipv4_hdr_stats.sv
hw/ipv4_forward_top.sv
testbench/ipv4_forward_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= ipv4_forward_tb
FILELIST  ?= build.f
MDIR      ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(MDIR) -o $(TOP)
	./$(MDIR)/$(TOP) | tee $(LOG)
	@grep -q "test passed" $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(MDIR) $(LOG)
